// ==== verilog.f ====
+incdir+logic
logic/cop_isa_pkg.sv
logic/cop_regs_pkg.sv
logic/cop_decode.sv
logic/cop_lane_permute.sv
logic/cop_palu.sv
logic/cop_cpr_file.sv
logic/cop_execute.sv
tb/cop_clock_gen.sv
tb/cop_tb.sv

// ==== Makefile ====
TOP := cop_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

obj_dir/V$(TOP): verilog.f $(wildcard logic/*.sv logic/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f verilog.f -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/cop_tb.sv ====
`default_nettype none

module cop_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic        g_clk;
    logic        reset;
    logic        insn_valid;
    logic [31:0] insn;
    logic [31:0] gpr_rs1;
    logic        insn_done;
    logic        insn_illegal;
    logic [2:0]  dbg_addr;
    logic [31:0] dbg_data;

    // Model state and bookkeeping
    logic [31:0] ref_regs [8];
    integer      seed = 32'h40bf;
    string       test_name = "none";
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    cop_clock_gen clock_gen_i (
        .g_clk (g_clk),
        .reset (reset)
    );

    cop_execute cop_execute_i (
        .g_clk        (g_clk),
        .reset        (reset),
        .insn_valid   (insn_valid),
        .insn         (insn),
        .gpr_rs1      (gpr_rs1),
        .insn_done    (insn_done),
        .insn_illegal (insn_illegal),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // a, b, c are the rs1, rs2 and rd values; returns the write data
    function automatic logic [31:0] cop_ref_exec(
        input  logic [31:0] w,
        input  logic [31:0] gpr,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] c,
        output logic        wen,
        output logic        ill
    );
        logic [31:0] data;
        logic [15:0] imm;
        logic [31:0] rot;
        int          start;
        int          len;
        int          amt;
        int          sel;
        int          byte_k;
        imm    = w[15:0];
        data   = c;
        wen    = 1'b1;
        ill    = 1'b0;
        // Field start and length in bit pairs
        start  = 2 * imm[7:4];
        len    = 2 * imm[3:0];
        byte_k = int'(w[28:25]) - 3;
        case (w[31:29])
            // Move
            3'd0: begin
                case (w[28:25])
                    4'd0: begin
                        data = a;
                        wen  = (b == 32'h0);
                    end
                    4'd1: begin
                        data = a;
                        wen  = (b != 32'h0);
                    end
                    4'd2: data = gpr;
                    default: ill = 1'b1;
                endcase
            end
            // Bitwise
            3'd1: begin
                case (w[28:25])
                    4'd0, 4'd1: begin
                        // hmix adds half a word to the rotation
                        amt = int'(imm[3:0]) + (w[25] ? 16 : 0);
                        rot = (a >> amt) | (a << (32 - amt));
                        for (int i = 0; i < 32; i++) begin
                            data[i] = b[i] ? rot[i] : c[i];
                        end
                    end
                    4'd2: begin
                        for (int i = 0; i < 32; i++) begin
                            data[i] = imm[2 * a[i] + b[i]];
                        end
                    end
                    4'd3: begin
                        for (int j = 0; j < len; j++) begin
                            if (start + j < 32) data[start + j] = a[j];
                        end
                    end
                    4'd4: begin
                        data = 32'h0;
                        for (int i = 0; i < len; i++) begin
                            if (i + start < 32) data[i] = a[i + start];
                        end
                    end
                    4'd5: data[15:0] = imm;
                    4'd6: data[31:16] = imm;
                    default: ill = 1'b1;
                endcase
            end
            // Twiddle, output lane k takes input lane imm[2k+1:2k]
            3'd3: begin
                data = a;
                for (int k = 0; k < 4; k++) begin
                    sel = int'(imm[2*k +: 2]);
                    case (w[28:25])
                        4'd0:    data[8*k +: 8]      = a[8*sel +: 8];
                        4'd1:    data[4*k +: 4]      = a[4*sel +: 4];
                        4'd2:    data[16+4*k +: 4]   = a[16+4*sel +: 4];
                        4'd3, 4'd4, 4'd5, 4'd6:
                            data[8*byte_k+2*k +: 2] = a[8*byte_k+2*sel +: 2];
                        default: ill = 1'b1;
                    endcase
                end
            end
            // Packed arith and unused classes
            default: ill = 1'b1;
        endcase
        if (ill) wen = 1'b0;
        return data;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------

    // Issue cycle flags, then every CPR as left by earlier instructions
    initial begin : compare
        logic [31:0] w;
        logic [31:0] exp_data;
        logic        v;
        logic        exp_we;
        logic        exp_ill;
        dbg_addr = 3'd0;
        foreach (ref_regs[r]) ref_regs[r] = 32'h0;
        forever begin
            @(posedge g_clk);
            #2;
            if (reset) begin
                foreach (ref_regs[r]) ref_regs[r] = 32'h0;
            end else begin
                v = insn_valid;
                w = insn;
                exp_data = cop_ref_exec(w, gpr_rs1, ref_regs[w[21:19]], ref_regs[w[18:16]],
                                        ref_regs[w[24:22]], exp_we, exp_ill);
                check_value("insn_done", {31'b0, v}, {31'b0, insn_done});
                check_value("insn_illegal", {31'b0, v & exp_ill}, {31'b0, insn_illegal});
                for (int r = 0; r < 8; r++) begin
                    dbg_addr = 3'(r);
                    #0.1;
                    check_value($sformatf("cpr%0d", r), ref_regs[r], dbg_data);
                end
                // Write lands at the coming edge
                if (v && exp_we) ref_regs[w[24:22]] = exp_data;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] encode_insn(input logic [2:0] cls, input logic [3:0] sub,
                                                input logic [2:0] rd, input logic [2:0] rs1,
                                                input logic [2:0] rs2, input logic [15:0] imm);
        return {cls, sub, rd, rs1, rs2, imm};
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    task automatic issue(input logic [31:0] word, input logic [31:0] gpr);
        @(posedge g_clk);
        #1;
        insn_valid = 1'b1;
        insn       = word;
        gpr_rs1    = gpr;
    endtask

    // Random registers and immediate, one random word for the fields
    task automatic issue_random(input logic [2:0] cls, input logic [3:0] sub);
        logic [31:0] r;
        r = rand_word();
        issue(encode_insn(cls, sub, r[2:0], r[5:3], r[8:6], r[31:16]), rand_word());
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge g_clk);
            #1;
            insn_valid = 1'b0;
            insn       = 32'h0;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    // Two idle cycles so the last write is swept
    task automatic finish_test();
        idle(2);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %-14s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-14s %0d mismatches", test_name, errors - errors_at_start);
        end
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (reset && cycles < 20) begin
            @(posedge g_clk);
            cycles++;
        end
        released = !reset;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        logic        released;
        logic [31:0] r;
        insn_valid = 1'b0;
        insn       = 32'h0;
        gpr_rs1    = 32'h0;
        #1;
        wait_reset_release(released);
        if (!released) begin
            errors++;
            $display("reset was still high after 20 clock cycles");
        end else begin
            // Zeros after reset, then mv2cop into every CPR
            start_test("reset_mv2cop");
            idle(1);
            for (int i = 0; i < 8; i++) issue(encode_insn(3'd0, 4'd2, 3'(i), 3'd0, 3'd0,
                                                          16'h0), rand_word());
            finish_test();

            start_test("cmov");
            // r7 cleared as the zero condition source
            issue(encode_insn(3'd0, 4'd2, 3'd7, 3'd0, 3'd0, 16'h0), 32'h0);
            issue(encode_insn(3'd0, 4'd0, 3'd1, 3'd2, 3'd7, 16'h0), 32'h0);
            issue(encode_insn(3'd0, 4'd0, 3'd3, 3'd4, 3'd5, 16'h0), 32'h0);
            issue(encode_insn(3'd0, 4'd1, 3'd4, 3'd0, 3'd7, 16'h0), 32'h0);
            issue(encode_insn(3'd0, 4'd1, 3'd5, 3'd6, 3'd2, 16'h0), 32'h0);
            for (int i = 0; i < 12; i++) issue_random(3'd0, 4'(i % 2));
            finish_test();

            // bop, ins, ext, lli, lui in turn
            start_test("bitwise");
            for (int i = 0; i < 30; i++) issue_random(3'd1, 4'(i % 5 + 2));
            // Fields that run past bit 31
            issue(encode_insn(3'd1, 4'd3, 3'd2, 3'd1, 3'd0, 16'h00f4), 32'h0);
            issue(encode_insn(3'd1, 4'd3, 3'd3, 3'd6, 3'd0, 16'h00e5), 32'h0);
            issue(encode_insn(3'd1, 4'd4, 3'd4, 3'd5, 3'd0, 16'h00f7), 32'h0);
            finish_test();

            start_test("mix");
            for (int i = 0; i < 16; i++) issue_random(3'd1, 4'(i % 2));
            finish_test();

            start_test("twiddle");
            for (int i = 0; i < 28; i++) issue_random(3'd3, 4'(i % 7));
            finish_test();

            start_test("illegal");
            for (int i = 0; i < 4; i++) begin
                r = rand_word();
                issue_random(3'd2, r[3:0]);
            end
            issue_random(3'd0, 4'd3);
            issue_random(3'd1, 4'd7);
            issue_random(3'd3, 4'd9);
            issue_random(3'd5, 4'd0);
            issue_random(3'd7, 4'd15);
            finish_test();

            // Each instruction reads the register written just before
            start_test("back_to_back");
            issue(encode_insn(3'd0, 4'd2, 3'd2, 3'd0, 3'd0, 16'h0), rand_word());
            issue(encode_insn(3'd1, 4'd2, 3'd3, 3'd2, 3'd2, 16'h000e), 32'h0);
            issue(encode_insn(3'd1, 4'd4, 3'd4, 3'd3, 3'd0, 16'h0048), 32'h0);
            issue(encode_insn(3'd3, 4'd0, 3'd4, 3'd4, 3'd0, 16'h001b), 32'h0);
            issue(encode_insn(3'd1, 4'd5, 3'd4, 3'd0, 3'd0, 16'hbeef), 32'h0);
            issue(encode_insn(3'd1, 4'd0, 3'd4, 3'd3, 3'd2, 16'h0007), 32'h0);
            finish_test();
        end
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/cop_clock_gen.sv ====
`default_nettype none

module cop_clock_gen (
    output logic g_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // Reset high for the first 4 rising edges, released 1 ns after the last
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge g_clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/cop_execute.sv ====
`default_nettype none

module cop_execute
    import cop_isa_pkg::*;
    import cop_regs_pkg::*;
(
    input  logic      g_clk,
    input  logic      reset,
    input  logic      insn_valid,
    input  cop_word_t insn,
    input  cop_word_t gpr_rs1,
    output logic      insn_done,
    output logic      insn_illegal,
    input  cop_ridx_t dbg_addr,
    output cop_word_t dbg_data
);

    // Decode outputs
    cop_op_t               dec_op;
    logic                  dec_illegal;
    cop_ridx_t             dec_rd;
    cop_ridx_t             dec_rs1;
    cop_ridx_t             dec_rs2;
    logic [insn_imm_w-1:0] dec_imm;

    // Operands and writeback
    cop_word_t             rs1_data;
    cop_word_t             rs2_data;
    cop_word_t             rs3_data;
    cop_ben_t              wb_ben;
    cop_word_t             wb_data;

    // Done rises with the strobe in the same cycle
    assign insn_done    = insn_valid;
    assign insn_illegal = insn_valid && dec_illegal;

    cop_decode cop_decode_i (
        .insn_valid (insn_valid),
        .insn       (insn),
        .op         (dec_op),
        .illegal    (dec_illegal),
        .rd         (dec_rd),
        .rs1        (dec_rs1),
        .rs2        (dec_rs2),
        .imm        (dec_imm)
    );

    // Third operand and write both address rd
    cop_cpr_file cop_cpr_file_i (
        .g_clk    (g_clk),
        .reset    (reset),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .rs3_addr (dec_rd),
        .wr_addr  (dec_rd),
        .dbg_addr (dbg_addr),
        .wr_ben   (wb_ben),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data),
        .dbg_data (dbg_data)
    );

    cop_palu cop_palu_i (
        .op       (dec_op),
        .imm      (dec_imm),
        .gpr_rs1  (gpr_rs1),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data),
        .wb_ben   (wb_ben),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// ==== logic/cop_cpr_file.sv ====
`default_nettype none

`include "cop_macros.svh"

module cop_cpr_file
    import cop_regs_pkg::*;
(
    input  logic      g_clk,
    input  logic      reset,
    input  cop_ridx_t rs1_addr,
    input  cop_ridx_t rs2_addr,
    input  cop_ridx_t rs3_addr,
    input  cop_ridx_t wr_addr,
    input  cop_ridx_t dbg_addr,
    input  cop_ben_t  wr_ben,
    input  cop_word_t wr_data,
    output cop_word_t rs1_data,
    output cop_word_t rs2_data,
    output cop_word_t rs3_data,
    output cop_word_t dbg_data
);

    cop_word_t cprs [`COP_NREGS];

    // ------------------------------------------------------------
    // Write port, byte granular
    // ------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int r = 0; r < `COP_NREGS; r++) begin
                cprs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < $bits(cop_ben_t); b++) begin
                if (wr_ben[b]) begin
                    cprs[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Read ports, all asynchronous
    // ------------------------------------------------------------

    // rs3 is wired to rd by the parent
    assign rs1_data = cprs[rs1_addr];
    assign rs2_data = cprs[rs2_addr];
    assign rs3_data = cprs[rs3_addr];

    // Debug view of any CPR
    assign dbg_data = cprs[dbg_addr];

    // Known data on every enabled write
    a_wr_data_known: assert property (
        @(posedge g_clk) disable iff (reset)
        (|wr_ben) |-> !$isunknown(wr_data)
    ) else $error("cpr write with unknown data");

endmodule

`default_nettype wire

// ==== logic/cop_palu.sv ====
`default_nettype none

`include "cop_macros.svh"

module cop_palu
    import cop_isa_pkg::*;
    import cop_regs_pkg::*;
(
    input  cop_op_t               op,
    input  logic [insn_imm_w-1:0] imm,
    input  cop_word_t             gpr_rs1,
    input  cop_word_t             rs1_data,
    input  cop_word_t             rs2_data,
    input  cop_word_t             rs3_data,
    output cop_ben_t              wb_ben,
    output cop_word_t             wb_data
);

    // Lane payloads for the twiddle permuters
    typedef logic [7:0] byte_lane_t;
    typedef logic [3:0] nibble_lane_t;
    typedef logic [1:0] crumb_lane_t;

    // Move
    logic                    cmov_cond;

    // Bitwise
    cop_word_t               bop_result;
    logic [4:0]              ei_start;
    logic [4:0]              ei_len;
    cop_word_t               ei_mask;
    cop_word_t               ext_result;
    cop_word_t               ins_result;
    logic [4:0]              mix_ramt;
    logic [2*`COP_XLEN-1:0]  mix_dbl;
    cop_word_t               mix_rot;
    cop_word_t               mix_result;

    // Twiddle
    logic [1:0]              twid_sel  [4];
    byte_lane_t              byte_in   [4];
    byte_lane_t              byte_out  [4];
    nibble_lane_t            nib_in    [4];
    nibble_lane_t            nib_out   [4];
    crumb_lane_t             crumb_in  [4];
    crumb_lane_t             crumb_out [4];
    logic [15:0]             nib_half;
    logic [1:0]              crumb_idx;
    logic [7:0]              crumb_byte;
    cop_word_t               twid_b_res;
    logic [15:0]             twid_n_out;
    logic [7:0]              twid_c_out;
    cop_word_t               twid_c_res;

    // ------------------------------------------------------------
    // Move
    // ------------------------------------------------------------

    // Condition is on rs2 being all zero
    assign cmov_cond = (rs2_data == '0);

    // ------------------------------------------------------------
    // Bitwise
    // ------------------------------------------------------------

    // BOP, imm[3:0] is a 2-input truth table per bit
    for (genvar i = 0; i < `COP_XLEN; i++) begin : g_bop
        assign bop_result[i] = imm[{rs1_data[i], rs2_data[i]}];
    end

    // EXT / INS fields, both counted in bit pairs
    assign ei_start = {imm[7:4], 1'b0};
    assign ei_len   = {imm[3:0], 1'b0};

    // Low len bits set, zero length gives empty mask
    assign ei_mask  = ~({`COP_XLEN{1'b1}} << ei_len);

    assign ext_result = (rs1_data >> ei_start) & ei_mask;

    // Field bits past bit 31 fall off the shift
    assign ins_result = ((rs1_data & ei_mask) << ei_start)
                      | (rs3_data & ~(ei_mask << ei_start));

    // MIX rotate amount, HMIX adds a half word
    assign mix_ramt = {op == op_hmix, imm[3:0]};

    // Rotate right via a doubled word
    assign mix_dbl = {rs1_data, rs1_data} >> mix_ramt;
    assign mix_rot = mix_dbl[`COP_XLEN-1:0];

    // rs2 picks rotated rs1, else keep rd
    assign mix_result = (rs2_data & mix_rot) | (~rs2_data & rs3_data);

    // ------------------------------------------------------------
    // Twiddle
    // ------------------------------------------------------------

    // Halfword for the nibble forms
    assign nib_half = (op == op_twid_n1) ? rs1_data[31:16] : rs1_data[15:0];

    // Byte under crumb permutation
    always_comb begin
        case (op)
            op_twid_c1: crumb_idx = 2'd1;
            op_twid_c2: crumb_idx = 2'd2;
            op_twid_c3: crumb_idx = 2'd3;
            default:    crumb_idx = 2'd0;
        endcase
    end

    assign crumb_byte = rs1_data[8*crumb_idx +: 8];

    // Lane split and gather, sel i comes from imm[2i+1:2i]
    for (genvar i = 0; i < 4; i++) begin : g_twid
        assign twid_sel[i]            = imm[2*i +: 2];
        assign byte_in[i]             = rs1_data[8*i +: 8];
        assign nib_in[i]              = nib_half[4*i +: 4];
        assign crumb_in[i]            = crumb_byte[2*i +: 2];
        assign twid_b_res[8*i +: 8]   = byte_out[i];
        assign twid_n_out[4*i +: 4]   = nib_out[i];
        assign twid_c_out[2*i +: 2]   = crumb_out[i];
    end

    cop_lane_permute #(
        .lane_t    (byte_lane_t)
    ) byte_permute_i (
        .lanes_in  (byte_in),
        .sel       (twid_sel),
        .lanes_out (byte_out)
    );

    cop_lane_permute #(
        .lane_t    (nibble_lane_t)
    ) nibble_permute_i (
        .lanes_in  (nib_in),
        .sel       (twid_sel),
        .lanes_out (nib_out)
    );

    cop_lane_permute #(
        .lane_t    (crumb_lane_t)
    ) crumb_permute_i (
        .lanes_in  (crumb_in),
        .sel       (twid_sel),
        .lanes_out (crumb_out)
    );

    // Other bytes of rs1 pass through
    always_comb begin
        twid_c_res                   = rs1_data;
        twid_c_res[8*crumb_idx +: 8] = twid_c_out;
    end

    // ------------------------------------------------------------
    // Writeback select
    // ------------------------------------------------------------
    always_comb begin
        wb_data = '0;
        wb_ben  = '1;
        case (op)
            op_mv2cop:  wb_data = gpr_rs1;
            op_cmov: begin
                wb_data = rs1_data;
                wb_ben  = {$bits(cop_ben_t){cmov_cond}};
            end
            op_cmovn: begin
                wb_data = rs1_data;
                wb_ben  = {$bits(cop_ben_t){!cmov_cond}};
            end
            op_lmix,
            op_hmix:    wb_data = mix_result;
            op_bop:     wb_data = bop_result;
            op_ins:     wb_data = ins_result;
            op_ext:     wb_data = ext_result;
            op_lli:     wb_data = {rs3_data[31:16], imm};
            op_lui:     wb_data = {imm, rs3_data[15:0]};
            op_twid_b:  wb_data = twid_b_res;
            op_twid_n0: wb_data = {rs1_data[31:16], twid_n_out};
            op_twid_n1: wb_data = {twid_n_out, rs1_data[15:0]};
            op_twid_c0,
            op_twid_c1,
            op_twid_c2,
            op_twid_c3: wb_data = twid_c_res;
            // Idle or illegal, nothing written
            default:    wb_ben  = '0;
        endcase
    end

    // No write without a decoded op
    always_comb begin
        if (op == op_none) begin
            assert final (wb_ben == '0)
                else $error("palu write enabled with no op");
        end
    end

endmodule

`default_nettype wire

// ==== logic/cop_lane_permute.sv ====
`default_nettype none

module cop_lane_permute #(
    parameter type lane_t = logic [7:0]
) (
    input  lane_t      lanes_in  [4],
    input  logic [1:0] sel       [4],
    output lane_t      lanes_out [4]
);

    // ------------------------------------------------------------
    // Four way crossbar
    // ------------------------------------------------------------

    // Each output lane is an independent 4:1 mux
    for (genvar i = 0; i < 4; i++) begin : g_lane
        always_comb begin
            case (sel[i])
                2'd0:    lanes_out[i] = lanes_in[0];
                2'd1:    lanes_out[i] = lanes_in[1];
                2'd2:    lanes_out[i] = lanes_in[2];
                default: lanes_out[i] = lanes_in[3];
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/cop_decode.sv ====
`default_nettype none

module cop_decode
    import cop_isa_pkg::*;
    import cop_regs_pkg::*;
(
    input  logic                  insn_valid,
    input  cop_word_t             insn,
    output cop_op_t               op,
    output logic                  illegal,
    output cop_ridx_t             rd,
    output cop_ridx_t             rs1,
    output cop_ridx_t             rs2,
    output logic [insn_imm_w-1:0] imm
);

    cop_class_t    insn_class;
    cop_subclass_t insn_subclass;
    logic          pair_legal;

    // Field split
    assign insn_class    = cop_class_t'(insn[insn_class_lsb +: $bits(cop_class_t)]);
    assign insn_subclass = insn[insn_subclass_lsb +: $bits(cop_subclass_t)];
    assign rd            = insn[insn_rd_lsb +: $bits(cop_ridx_t)];
    assign rs1           = insn[insn_rs1_lsb +: $bits(cop_ridx_t)];
    assign rs2           = insn[insn_rs2_lsb +: $bits(cop_ridx_t)];
    assign imm           = insn[insn_imm_w-1:0];

    // ------------------------------------------------------------
    // Class and subclass to op
    // ------------------------------------------------------------
    always_comb begin
        op = op_none;
        case (insn_class)
            cls_move: begin
                case (insn_subclass)
                    sc_cmov:    op = op_cmov;
                    sc_cmovn:   op = op_cmovn;
                    sc_mv2cop:  op = op_mv2cop;
                    default:    op = op_none;
                endcase
            end
            cls_bitwise: begin
                case (insn_subclass)
                    sc_lmix:    op = op_lmix;
                    sc_hmix:    op = op_hmix;
                    sc_bop:     op = op_bop;
                    sc_ins:     op = op_ins;
                    sc_ext:     op = op_ext;
                    sc_lli:     op = op_lli;
                    sc_lui:     op = op_lui;
                    default:    op = op_none;
                endcase
            end
            cls_twiddle: begin
                case (insn_subclass)
                    sc_twid_b:  op = op_twid_b;
                    sc_twid_n0: op = op_twid_n0;
                    sc_twid_n1: op = op_twid_n1;
                    sc_twid_c0: op = op_twid_c0;
                    sc_twid_c1: op = op_twid_c1;
                    sc_twid_c2: op = op_twid_c2;
                    sc_twid_c3: op = op_twid_c3;
                    default:    op = op_none;
                endcase
            end
            // Packed arith and unused classes fall through
            default: op = op_none;
        endcase
        // No strobe, no op
        if (!insn_valid) begin
            op = op_none;
        end
    end

    // Legality from subclass ranges, independent of the op table
    always_comb begin
        case (insn_class)
            cls_move:    pair_legal = insn_subclass <= sc_mv2cop;
            cls_bitwise: pair_legal = insn_subclass <= sc_lui;
            cls_twiddle: pair_legal = insn_subclass <= sc_twid_c3;
            default:     pair_legal = 1'b0;
        endcase
    end

    assign illegal = insn_valid && !pair_legal;

    // Op table and range check must agree
    always_comb begin
        if (insn_valid) begin
            assert final ((op == op_none) == illegal)
                else $error("decode op table and legality check disagree");
        end
    end

endmodule

`default_nettype wire

// ==== logic/cop_regs_pkg.sv ====
`default_nettype none

`include "cop_macros.svh"

package cop_regs_pkg;

    // One CPR or GPR value
    typedef logic [`COP_XLEN-1:0] cop_word_t;

    // CPR index
    typedef logic [`COP_RIDX_W-1:0] cop_ridx_t;

    // Byte enables, bit i covers byte i of a word
    typedef logic [`COP_XLEN/8-1:0] cop_ben_t;

endpackage

`default_nettype wire

// ==== logic/cop_isa_pkg.sv ====
`default_nettype none

package cop_isa_pkg;

    // ------------------------------------------------------------
    // Instruction word layout
    // ------------------------------------------------------------

    // 31:29 class, 28:25 subclass, 24:22 rd, 21:19 rs1, 18:16 rs2
    localparam int insn_class_lsb    = 29;
    localparam int insn_subclass_lsb = 25;
    localparam int insn_rd_lsb       = 22;
    localparam int insn_rs1_lsb      = 19;
    localparam int insn_rs2_lsb      = 16;

    // Immediate sits in the low halfword
    localparam int insn_imm_w        = 16;

    // Top level instruction class
    typedef enum logic [2:0] {
        cls_move    = 3'd0,
        cls_bitwise = 3'd1,
        cls_parith  = 3'd2,
        cls_twiddle = 3'd3
    } cop_class_t;

    typedef logic [3:0] cop_subclass_t;

    // ------------------------------------------------------------
    // Subclass codes, meaning depends on the class
    // ------------------------------------------------------------

    // Move
    localparam cop_subclass_t sc_cmov    = 4'd0;
    localparam cop_subclass_t sc_cmovn   = 4'd1;
    localparam cop_subclass_t sc_mv2cop  = 4'd2;

    // Bitwise
    localparam cop_subclass_t sc_lmix    = 4'd0;
    localparam cop_subclass_t sc_hmix    = 4'd1;
    localparam cop_subclass_t sc_bop     = 4'd2;
    localparam cop_subclass_t sc_ins     = 4'd3;
    localparam cop_subclass_t sc_ext     = 4'd4;
    localparam cop_subclass_t sc_lli     = 4'd5;
    localparam cop_subclass_t sc_lui     = 4'd6;

    // Twiddle
    localparam cop_subclass_t sc_twid_b  = 4'd0;
    localparam cop_subclass_t sc_twid_n0 = 4'd1;
    localparam cop_subclass_t sc_twid_n1 = 4'd2;
    localparam cop_subclass_t sc_twid_c0 = 4'd3;
    localparam cop_subclass_t sc_twid_c1 = 4'd4;
    localparam cop_subclass_t sc_twid_c2 = 4'd5;
    localparam cop_subclass_t sc_twid_c3 = 4'd6;

    // One flat op per legal class and subclass pair
    typedef enum logic [4:0] {
        op_none,
        op_cmov, op_cmovn, op_mv2cop,
        op_lmix, op_hmix, op_bop, op_ins, op_ext, op_lli, op_lui,
        op_twid_b, op_twid_n0, op_twid_n1,
        op_twid_c0, op_twid_c1, op_twid_c2, op_twid_c3
    } cop_op_t;

endpackage

`default_nettype wire

// ==== logic/cop_macros.svh ====
`ifndef COP_MACROS_SVH
`define COP_MACROS_SVH

// Width of a CPR, a GPR and the packed ALU datapath
`define COP_XLEN 32

// Number of coprocessor registers
`define COP_NREGS 8

// Index width for one CPR, log2 of the register count
`define COP_RIDX_W 3

`endif
